//--- common/spart_config.svh
`ifndef SPART_CONFIG_SVH
`define SPART_CONFIG_SVH

// Default baud divisor
// Baud enable period is divisor + 1 clocks
`define SPART_DIV_DEFAULT 16'h00A3

// Baud enables per serial bit
`define SPART_OVERSAMPLE 16

// Bytes moved per 32-bit word
`define SPART_WORD_BYTES 4

`endif

//--- common/spart_pkg.sv
package spart_pkg;

	//////////////////////////////////////////////////
	// Driver sequencing
	//////////////////////////////////////////////////

	// PROG_LO and PROG_HI program the divisor after reset
	// IDLE picks the next byte access
	// WRITE and READ hold iocs high for exactly one cycle
	typedef enum logic [2:0] {
		PROG_LO = 3'd0,
		PROG_HI = 3'd1,
		IDLE    = 3'd2,
		WRITE   = 3'd3,
		READ    = 3'd4
	} drv_state_t;

	//////////////////////////////////////////////////
	// SPART register map
	//////////////////////////////////////////////////

	// DATA is the transmit buffer on a write, receive buffer on a read
	// STATUS reads back {rda, tbr} in the low two bits
	// DIV_LO and DIV_HI are write-only divisor halves
	typedef enum logic [1:0] {
		DATA   = 2'd0,
		STATUS = 2'd1,
		DIV_LO = 2'd2,
		DIV_HI = 2'd3
	} io_addr_t;

endpackage

//--- common/spart_bus_if.sv
`timescale 1ns/10ps

interface spart_bus_if;
	import spart_pkg::*;

	// Access strobe, one cycle per access
	logic     iocs;
	// High for read, low for write
	logic     iorw;
	io_addr_t ioaddr;
	// Shared byte bus, one driver at a time
	tri [7:0] databus;
	// Receive data available
	logic     rda;
	// Transmit buffer ready
	logic     tbr;

	// Word-side bridge
	modport driver (
		output iocs, iorw, ioaddr,
		input  rda, tbr,
		inout  databus
	);

	// SPART core
	modport spart (
		input  iocs, iorw, ioaddr,
		output rda, tbr,
		inout  databus
	);

endinterface

//--- spart/spart_tx.sv
`timescale 1ns/10ps
`include "spart_config.svh"

module spart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       baud_en,
	input  logic       load,
	input  logic [7:0] load_data,
	output logic       tbr,
	output logic       txd
);
	localparam int OS = `SPART_OVERSAMPLE;
	localparam int EW = $clog2(OS);

	// Stop, data LSB first, start
	logic [9:0]    frame;
	logic          active;
	logic [EW-1:0] en_cnt;
	logic [3:0]    bit_cnt;
	logic          bit_end;

	// Last enable of the current bit
	assign bit_end = active && baud_en && (en_cnt == EW'(OS - 1));

	always_ff @(posedge clk)
	begin
		if (load)
			frame <= {1'b1, load_data, 1'b0};
		else if (bit_end)
			frame <= {1'b1, frame[9:1]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tbr     <= 1'b1;
			active  <= 1'b0;
			en_cnt  <= '0;
			bit_cnt <= 4'd0;
		end
		else if (load)
			tbr <= 1'b0;
		else if (!tbr && !active && baud_en)
		begin
			// Byte waiting, start bit begins here
			active  <= 1'b1;
			en_cnt  <= '0;
			bit_cnt <= 4'd0;
		end
		else if (bit_end)
		begin
			en_cnt <= '0;
			// Stop bit done
			if (bit_cnt == 4'd9)
			begin
				active <= 1'b0;
				tbr    <= 1'b1;
			end
			else
				bit_cnt <= bit_cnt + 4'd1;
		end
		else if (active && baud_en)
			en_cnt <= en_cnt + 1'b1;
	end

	// Line idles high
	assign txd = active ? frame[0] : 1'b1;

endmodule

//--- spart/spart_rx.sv
`timescale 1ns/10ps
`include "spart_config.svh"

module spart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       baud_en,
	input  logic       rxd,
	input  logic       rd_pop,
	output logic [7:0] rx_data,
	output logic       rda
);
	localparam int OS = `SPART_OVERSAMPLE;
	localparam int EW = $clog2(OS);

	// Two-flop synchronizer plus a third flop for edge detect
	logic          rxd_s1;
	logic          rxd_s2;
	logic          rxd_s3;
	logic          busy;
	logic [EW-1:0] en_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]    bit_cnt;
	logic [7:0]    shift;
	logic          sample;
	logic          stop_ok;

	// Mid-bit sample on the 8th enable of each bit
	assign sample  = busy && baud_en && (en_cnt == EW'(OS/2 - 1));
	assign stop_ok = sample && (bit_cnt == 4'd9) && rxd_s2;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_s3 <= 1'b1;
		end
		else
		begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
			rxd_s3 <= rxd_s2;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			en_cnt  <= '0;
			bit_cnt <= 4'd0;
		end
		else if (!busy)
		begin
			// Falling edge of a start bit
			if (rxd_s3 && !rxd_s2)
			begin
				busy    <= 1'b1;
				en_cnt  <= '0;
				bit_cnt <= 4'd0;
			end
		end
		else if (baud_en)
		begin
			en_cnt <= en_cnt + 1'b1;
			if (sample)
			begin
				bit_cnt <= bit_cnt + 4'd1;
				// Start bit gone by mid-bit means a glitch
				if (bit_cnt == 4'd0 && rxd_s2)
					busy <= 1'b0;
				if (bit_cnt == 4'd9)
					busy <= 1'b0;
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk)
	begin
		if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9)
			shift <= {rxd_s2, shift[7:1]};
		if (stop_ok)
			rx_data <= shift;
	end

	// New frame wins over a pop in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			rda <= 1'b0;
		else if (stop_ok)
			rda <= 1'b1;
		else if (rd_pop)
			rda <= 1'b0;
	end

	// rda only rises once a frame has ended on a high stop sample
	a_stop_ok: assert property (@(posedge clk) disable iff (rst)
		$rose(rda) |-> ($past(bit_cnt == 4'd9 && rxd_s2) && !busy));

endmodule

//--- spart/spart.sv
`timescale 1ns/10ps

module spart (
	input  logic       clk,
	input  logic       rst,
	spart_bus_if.spart bus,
	output logic       txd,
	input  logic       rxd
);
	import spart_pkg::*;

	logic [7:0]  div_lo;
	logic [7:0]  div_hi;
	logic [15:0] baud_cnt;
	logic        baud_en;
	logic        load;
	logic        rd_pop;
	logic        rd_sel;
	logic [7:0]  rd_val;
	logic [7:0]  rx_data;
	logic        tbr;
	logic        rda;

	//////////////////////////////////////////////////
	// Bus decode
	//////////////////////////////////////////////////

	assign load   = bus.iocs && !bus.iorw && (bus.ioaddr == DATA);
	assign rd_pop = bus.iocs && bus.iorw && (bus.ioaddr == DATA);
	assign rd_sel = bus.iocs && bus.iorw &&
		(bus.ioaddr == DATA || bus.ioaddr == STATUS);

	// Status in the low bits, receive byte otherwise
	assign rd_val      = (bus.ioaddr == STATUS) ? {6'd0, rda, tbr} : rx_data;
	assign bus.databus = rd_sel ? rd_val : 'z;
	assign bus.rda     = rda;
	assign bus.tbr     = tbr;

	// Divisor halves
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_lo <= 8'd0;
			div_hi <= 8'd0;
		end
		else if (bus.iocs && !bus.iorw)
		begin
			if (bus.ioaddr == DIV_LO)
				div_lo <= bus.databus;
			if (bus.ioaddr == DIV_HI)
				div_hi <= bus.databus;
		end
	end

	//////////////////////////////////////////////////
	// Baud enable, 16x bit rate
	//////////////////////////////////////////////////

	// Down counter, one pulse every divisor + 1 clocks
	always_ff @(posedge clk)
	begin
		if (rst)
			baud_cnt <= 16'd0;
		else if (baud_cnt == 16'd0)
			baud_cnt <= {div_hi, div_lo};
		else
			baud_cnt <= baud_cnt - 16'd1;
	end

	assign baud_en = (baud_cnt == 16'd0);

	spart_tx u_tx (
		.clk       (clk),
		.rst       (rst),
		.baud_en   (baud_en),
		.load      (load),
		.load_data (bus.databus),
		.tbr       (tbr),
		.txd       (txd)
	);

	spart_rx u_rx (
		.clk     (clk),
		.rst     (rst),
		.baud_en (baud_en),
		.rxd     (rxd),
		.rd_pop  (rd_pop),
		.rx_data (rx_data),
		.rda     (rda)
	);

	// Bus master must wait for tbr before loading a byte
	a_load_tbr: assert property (@(posedge clk) disable iff (rst) load |-> tbr);

endmodule

//--- driver/spart_driver.sv
`timescale 1ns/10ps
`include "spart_config.svh"

module spart_driver #(
	parameter logic [15:0] DIVISOR = `SPART_DIV_DEFAULT
) (
	input  logic        clk,
	input  logic        rst,
	spart_bus_if.driver bus,
	input  logic        word_wr,
	input  logic        word_rd,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data,
	output logic        write_ready,
	output logic        read_ready
);
	import spart_pkg::*;

	localparam int NBYTES = `SPART_WORD_BYTES;
	localparam int CW     = $clog2(NBYTES);

	drv_state_t    state;
	// Registered bus outputs
	logic          iocs_q;
	logic          iorw_q;
	io_addr_t      addr_q;
	logic [7:0]    dout_q;
	// Write side
	logic [31:0]   wr_word;
	logic          wr_busy;
	logic [CW-1:0] wr_cnt;
	// Read side
	logic          rd_armed;
	logic [CW-1:0] rd_cnt;

	assign bus.iocs   = iocs_q;
	assign bus.iorw   = iorw_q;
	assign bus.ioaddr = addr_q;
	// Drive the byte bus only during our own write access
	assign bus.databus = (iocs_q && !iorw_q) ? dout_q : 'z;

	//////////////////////////////////////////////////
	// Access sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state  <= PROG_LO;
			iocs_q <= 1'b0;
			iorw_q <= 1'b1;
			addr_q <= DATA;
		end
		else
		begin
			case (state)
				// Divisor low byte
				PROG_LO:
				begin
					iocs_q <= 1'b1;
					iorw_q <= 1'b0;
					addr_q <= DIV_LO;
					state  <= PROG_HI;
				end
				// Divisor high byte
				PROG_HI:
				begin
					iocs_q <= 1'b1;
					iorw_q <= 1'b0;
					addr_q <= DIV_HI;
					state  <= IDLE;
				end
				IDLE:
				begin
					addr_q <= DATA;
					// Receive first since a waiting byte gets overwritten
					if (rd_armed && bus.rda)
					begin
						iocs_q <= 1'b1;
						iorw_q <= 1'b1;
						state  <= READ;
					end
					else if (wr_busy && bus.tbr)
					begin
						iocs_q <= 1'b1;
						iorw_q <= 1'b0;
						state  <= WRITE;
					end
					else
					begin
						iocs_q <= 1'b0;
						iorw_q <= 1'b1;
					end
				end
				// WRITE and READ release the bus after one cycle
				default:
				begin
					iocs_q <= 1'b0;
					iorw_q <= 1'b1;
					state  <= IDLE;
				end
			endcase
		end
	end

	// Byte to put on the bus for the next write
	always_ff @(posedge clk)
	begin
		case (state)
			PROG_LO: dout_q <= DIVISOR[7:0];
			PROG_HI: dout_q <= DIVISOR[15:8];
			default: dout_q <= wr_word[8*wr_cnt +: 8];
		endcase
	end

	//////////////////////////////////////////////////
	// Word write with LSB first
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			write_ready <= 1'b0;
			wr_busy     <= 1'b0;
			wr_cnt      <= '0;
		end
		else if (state == PROG_HI)
			write_ready <= 1'b1;
		else if (word_wr && write_ready)
		begin
			write_ready <= 1'b0;
			wr_busy     <= 1'b1;
		end
		else if (state == WRITE)
		begin
			// Last byte latched by the SPART on this edge
			if (wr_cnt == CW'(NBYTES - 1))
			begin
				wr_cnt      <= '0;
				wr_busy     <= 1'b0;
				write_ready <= 1'b1;
			end
			else
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (word_wr && write_ready)
			wr_word <= wr_data;
	end

	//////////////////////////////////////////////////
	// Word read with LSB first
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_armed   <= 1'b0;
			rd_cnt     <= '0;
			read_ready <= 1'b0;
		end
		else if (state == READ)
		begin
			if (rd_cnt == CW'(NBYTES - 1))
			begin
				rd_cnt     <= '0;
				rd_armed   <= 1'b0;
				read_ready <= 1'b1;
			end
			else
				rd_cnt <= rd_cnt + 1'b1;
		end
		else if (word_rd && !rd_armed)
		begin
			rd_armed   <= 1'b1;
			read_ready <= 1'b0;
		end
	end

	// SPART drives the receive byte during READ
	always_ff @(posedge clk)
	begin
		if (state == READ)
			rd_data[8*rd_cnt +: 8] <= bus.databus;
	end

	// Data accesses on the bus last exactly one cycle
	a_single_access: assert property (@(posedge clk) disable iff (rst)
		(bus.iocs && bus.ioaddr == DATA) |=> !bus.iocs);

	// No new word accepted until all bytes are handed over
	a_ready_idle: assert property (@(posedge clk) disable iff (rst)
		wr_busy |-> !write_ready);

endmodule

//--- hdl/spart_word_top.sv
`timescale 1ns/10ps
`include "spart_config.svh"

module spart_word_top #(
	parameter logic [15:0] DIVISOR = `SPART_DIV_DEFAULT
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        word_wr,
	input  logic        word_rd,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data,
	output logic        write_ready,
	output logic        read_ready,
	output logic        txd,
	input  logic        rxd
);

	// Byte bus between bridge and core
	spart_bus_if bus ();

	spart_driver #(
		.DIVISOR (DIVISOR)
	) u_driver (
		.clk         (clk),
		.rst         (rst),
		.bus         (bus.driver),
		.word_wr     (word_wr),
		.word_rd     (word_rd),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.write_ready (write_ready),
		.read_ready  (read_ready)
	);

	spart u_spart (
		.clk (clk),
		.rst (rst),
		.bus (bus.spart),
		.txd (txd),
		.rxd (rxd)
	);

endmodule

//--- tb/spart_word_tb.sv
`timescale 1ns/10ps
`include "spart_config.svh"

module spart_word_tb;

	localparam logic [15:0] DIVISOR = 16'd3;
	localparam int CLK_NS   = 10;
	// Clocks per serial bit (64 with this divisor)
	localparam int BIT_CLKS = (DIVISOR + 1) * `SPART_OVERSAMPLE;
	localparam int NBYTES   = `SPART_WORD_BYTES;
	localparam int N_RANDOM = 20;
	// Words crossing the line in either direction
	localparam int NUM_WORDS   = 3 + 2 + 2 * N_RANDOM;
	localparam int WATCHDOG_NS = (NUM_WORDS * 40 + 200) * BIT_CLKS * CLK_NS;
	// Longest single wait covers several word bursts
	localparam int WAIT_CLKS = 3 * 40 * BIT_CLKS;

	logic        clk;
	logic        rst;
	logic        word_wr;
	logic        word_rd;
	logic [31:0] wr_data;
	logic [31:0] rd_data;
	logic        write_ready;
	logic        read_ready;
	logic        txd;
	logic        rxd;

	int          errors;
	int          tx_words_sent;
	int          tx_words_seen;
	// Words expected on txd with the oldest first
	logic [31:0] tx_expect [$];
	logic [31:0] wr_words [N_RANDOM];
	logic [31:0] rd_words [N_RANDOM];
	int          wr_gap [N_RANDOM];

	spart_word_top #(
		.DIVISOR (DIVISOR)
	) UUT (
		.clk         (clk),
		.rst         (rst),
		.word_wr     (word_wr),
		.word_rd     (word_rd),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.write_ready (write_ready),
		.read_ready  (read_ready),
		.txd         (txd),
		.rxd         (rxd)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Poll a ready level from 1 ns after a clock edge
	task automatic wait_ready(input bit for_read);
		int n;
		n = 0;
		while ((for_read ? read_ready : write_ready) !== 1'b1 && n < WAIT_CLKS)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if ((for_read ? read_ready : write_ready) !== 1'b1)
		begin
			errors++;
			$display("Gave up at %0t ns waiting for %s to rise", $time,
				for_read ? "read_ready" : "write_ready");
		end
	endtask

	task automatic write_word(input logic [31:0] data);
		wait_ready(1'b0);
		word_wr = 1'b1;
		wr_data = data;
		tx_expect.push_back(data);
		tx_words_sent++;
		@(posedge clk);
		#1;
		word_wr = 1'b0;
		check_equal(write_ready, 1'b0, "write_ready after accept");
	endtask

	task automatic hold_rxd(input logic level, input int clocks);
		rxd = level;
		repeat (clocks) @(posedge clk);
		#1;
	endtask

	// 8N1 frame followed by one idle bit time
	task automatic send_frame(input logic [7:0] data, input logic stop);
		int i;
		hold_rxd(1'b0, BIT_CLKS);
		for (i = 0; i < 8; i++)
			hold_rxd(data[i], BIT_CLKS);
		hold_rxd(stop, BIT_CLKS);
		hold_rxd(1'b1, BIT_CLKS);
	endtask

	task automatic arm_read();
		word_rd = 1'b1;
		@(posedge clk);
		#1;
		word_rd = 1'b0;
		check_equal(read_ready, 1'b0, "read_ready after word_rd");
	endtask

	// Bytes go out LSB first and the word comes back little-endian
	task automatic receive_word(input logic [31:0] word);
		int i;
		for (i = 0; i < NBYTES; i++)
		begin
			check_equal(read_ready, 1'b0, "read_ready before last byte");
			send_frame(word[8*i +: 8], 1'b1);
		end
		wait_ready(1'b1);
		check_equal(rd_data, word, "rd_data");
	endtask

	task automatic wait_tx_drain();
		int n;
		n = 0;
		while (tx_words_seen != tx_words_sent && n < WAIT_CLKS)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (tx_words_seen != tx_words_sent)
		begin
			errors++;
			$display("Only %0d of %0d written words came out on txd",
				tx_words_seen, tx_words_sent);
		end
	endtask

	// Line model for txd sampling on the falling clock edge
	task automatic receive_tx_byte(output logic [7:0] data);
		int i;
		@(negedge clk);
		while (txd !== 1'b0)
			@(negedge clk);
		// Middle of the start bit
		repeat (BIT_CLKS / 2) @(negedge clk);
		check_equal(txd, 1'b0, "txd start bit");
		for (i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge clk);
			data[i] = txd;
		end
		repeat (BIT_CLKS) @(negedge clk);
		check_equal(txd, 1'b1, "txd stop bit");
	endtask

	initial
	begin : txd_monitor
		logic [31:0] word;
		logic [7:0]  data;
		int          nbyte;
		@(negedge rst);
		forever
		begin
			word = '0;
			for (nbyte = 0; nbyte < NBYTES; nbyte++)
			begin
				receive_tx_byte(data);
				word[8*nbyte +: 8] = data;
			end
			if (tx_expect.size() == 0)
			begin
				errors++;
				$display("Word %h showed up on txd without a write", word);
			end
			else
				check_equal(word, tx_expect.pop_front(), "word on txd");
			tx_words_seen++;
		end
	end

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		$display("Simulation hung, watchdog expired after %0d ns", WATCHDOG_NS);
		$display("Closing: %0d errors, %0d of %0d txd words checked",
			errors, tx_words_seen, tx_words_sent);
		$display("Verification failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin : main
		int i;
		void'($urandom(93));
		errors        = 0;
		tx_words_sent = 0;
		tx_words_seen = 0;
		rst     = 1'b1;
		word_wr = 1'b0;
		word_rd = 1'b0;
		wr_data = '0;
		rxd     = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Quiet port after reset
		check_equal(write_ready, 1'b0, "write_ready after reset");
		check_equal(read_ready, 1'b0, "read_ready after reset");
		wait_ready(1'b0);
		for (i = 0; i < BIT_CLKS; i++)
		begin
			check_equal(txd, 1'b1, "idle txd");
			@(posedge clk);
			#1;
		end

		// One word out on txd
		write_word($urandom());
		wait_tx_drain();

		// Strobes while busy are dropped
		write_word($urandom());
		for (i = 0; i < 3; i++)
		begin
			word_wr = 1'b1;
			wr_data = $urandom();
			check_equal(write_ready, 1'b0, "write_ready while busy");
			@(posedge clk);
			#1;
		end
		word_wr = 1'b0;
		write_word($urandom());
		wait_tx_drain();

		// One word in on rxd
		arm_read();
		receive_word($urandom());

		// Frame with a bad stop bit never reaches the word
		arm_read();
		send_frame($urandom_range(255), 1'b0);
		check_equal(read_ready, 1'b0, "read_ready after framing error");
		receive_word($urandom());

		// Random traffic both ways at once
		for (i = 0; i < N_RANDOM; i++)
		begin
			wr_words[i] = $urandom();
			rd_words[i] = $urandom();
			wr_gap[i]   = $urandom_range(BIT_CLKS * 4);
		end
		fork
			begin : writer
				int k;
				for (k = 0; k < N_RANDOM; k++)
				begin
					write_word(wr_words[k]);
					repeat (wr_gap[k]) @(posedge clk);
					#1;
				end
			end
			begin : reader
				int k;
				for (k = 0; k < N_RANDOM; k++)
				begin
					arm_read();
					receive_word(rd_words[k]);
				end
			end
		join
		wait_tx_drain();

		$display("Closing: %0d errors, %0d of %0d txd words checked",
			errors, tx_words_seen, tx_words_sent);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+common
common/spart_pkg.sv
common/spart_bus_if.sv
spart/spart_tx.sv
spart/spart_rx.sv
spart/spart.sv
driver/spart_driver.sv
hdl/spart_word_top.sv
tb/spart_word_tb.sv

//--- Bender.yml
package:
  name: spart_word

export_include_dirs:
  - common

sources:
  - files:
      - common/spart_pkg.sv
      - common/spart_bus_if.sv
      - spart/spart_tx.sv
      - spart/spart_rx.sv
      - spart/spart.sv
      - driver/spart_driver.sv
      - hdl/spart_word_top.sv
  - target: test
    files:
      - tb/spart_word_tb.sv
